/* mpu.f */
+incdir+tb
logic/mpu_pkg.sv
logic/mpu_chk_if.sv
logic/mpu_pmp.sv
logic/mpu_pma.sv
logic/mpu_gate.sv
logic/mpu_top.sv
tb/mpu_tb.sv

/* Bender.yml */
package:
  name: mpu

sources:
  - files:
      - logic/mpu_pkg.sv
      - logic/mpu_chk_if.sv
      - logic/mpu_pmp.sv
      - logic/mpu_pma.sv
      - logic/mpu_gate.sv
      - logic/mpu_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/mpu_tb.sv

/* tb/mpu_tb_cases.svh */
// Request table and PMP configuration sets, included inside the MPU testbench module
`ifndef MPU_TB_CASES_SVH
`define MPU_TB_CASES_SVH

// PMP sets, entry 3 down to entry 0
// Set 0 NAPOT over everything with RWX
// Set 1 TOR R below 0x10000, NA4 RW at 0x10000, locked NAPOT R over peripherals
// Set 2 locked NAPOT R over boot ROM
localparam logic [3:0][7:0] PMP_CFG_SET [3] = '{
  32'h0000_001F,
  32'h0099_1309,
  32'h0000_0099
};
localparam logic [3:0][31:0] PMP_ADDR_SET [3] = '{
  {32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'hFFFF_FFFF},
  {32'h0000_0000, 32'h0400_1FFF, 32'h0000_4000, 32'h0000_4000},
  {32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h2000_1FFF}
};

localparam int NUM_CASES = 31;

// Columns: addr, we, exec, misaligned, priv, PMP set, expected status, expected memtype
// Memtype is {cacheable, bufferable} and only checked for clean requests
localparam case_t CASES [NUM_CASES] = '{
  // PMA regions with open PMP
  '{32'h0000_0100, 1'b0, 1'b0, 1'b0, mpu_pkg::PRIV_U, 2'd0, mpu_pkg::MPU_OK, 2'b11},
  '{32'h0000_0200, 1'b1, 1'b0, 1'b0, mpu_pkg::PRIV_U, 2'd0, mpu_pkg::MPU_OK, 2'b11},
  '{32'h1000_0010, 1'b0, 1'b0, 1'b0, mpu_pkg::PRIV_U, 2'd0, mpu_pkg::MPU_OK, 2'b01},
  '{32'h1000_0020, 1'b1, 1'b0, 1'b0, mpu_pkg::PRIV_U, 2'd0, mpu_pkg::MPU_OK, 2'b01},
  '{32'h8000_0040, 1'b0, 1'b1, 1'b0, mpu_pkg::PRIV_U, 2'd0, mpu_pkg::MPU_OK, 2'b10},
  '{32'h0000_0302, 1'b0, 1'b0, 1'b1, mpu_pkg::PRIV_U, 2'd0, mpu_pkg::MPU_OK, 2'b11},
  // Unmapped, just past RAM, fetch from peripherals, misaligned peripheral
  '{32'h2000_0000, 1'b0, 1'b0, 1'b0, mpu_pkg::PRIV_M, 2'd0, mpu_pkg::MPU_RE_FAULT, 2'b00},
  '{32'h0004_0000, 1'b1, 1'b0, 1'b0, mpu_pkg::PRIV_M, 2'd0, mpu_pkg::MPU_WR_FAULT, 2'b00},
  '{32'h1000_0100, 1'b0, 1'b1, 1'b0, mpu_pkg::PRIV_M, 2'd0, mpu_pkg::MPU_RE_FAULT, 2'b00},
  '{32'h1000_0102, 1'b1, 1'b0, 1'b1, mpu_pkg::PRIV_U, 2'd0, mpu_pkg::MPU_WR_FAULT, 2'b00},
  // Back to back, fault lands behind transactions in flight
  '{32'h0000_1000, 1'b0, 1'b0, 1'b0, mpu_pkg::PRIV_U, 2'd0, mpu_pkg::MPU_OK, 2'b11},
  '{32'h8000_1000, 1'b0, 1'b0, 1'b0, mpu_pkg::PRIV_M, 2'd0, mpu_pkg::MPU_OK, 2'b10},
  '{32'h1000_0200, 1'b0, 1'b0, 1'b0, mpu_pkg::PRIV_U, 2'd0, mpu_pkg::MPU_OK, 2'b01},
  '{32'h3000_0000, 1'b1, 1'b0, 1'b0, mpu_pkg::PRIV_U, 2'd0, mpu_pkg::MPU_WR_FAULT, 2'b00},
  // TOR region with R only
  '{32'h0000_0400, 1'b0, 1'b0, 1'b0, mpu_pkg::PRIV_U, 2'd1, mpu_pkg::MPU_OK, 2'b11},
  '{32'h0000_0400, 1'b1, 1'b0, 1'b0, mpu_pkg::PRIV_U, 2'd1, mpu_pkg::MPU_WR_FAULT, 2'b00},
  '{32'h0000_0800, 1'b0, 1'b1, 1'b0, mpu_pkg::PRIV_U, 2'd1, mpu_pkg::MPU_RE_FAULT, 2'b00},
  // NA4 word with RW, neighbour word unmatched
  '{32'h0001_0000, 1'b1, 1'b0, 1'b0, mpu_pkg::PRIV_U, 2'd1, mpu_pkg::MPU_OK, 2'b11},
  '{32'h0001_0004, 1'b1, 1'b0, 1'b0, mpu_pkg::PRIV_U, 2'd1, mpu_pkg::MPU_WR_FAULT, 2'b00},
  '{32'h0001_0000, 1'b0, 1'b1, 1'b0, mpu_pkg::PRIV_U, 2'd1, mpu_pkg::MPU_RE_FAULT, 2'b00},
  // Locked NAPOT over peripherals binds M-mode as well
  '{32'h1000_0300, 1'b0, 1'b0, 1'b0, mpu_pkg::PRIV_U, 2'd1, mpu_pkg::MPU_OK, 2'b01},
  '{32'h1000_0304, 1'b1, 1'b0, 1'b0, mpu_pkg::PRIV_U, 2'd1, mpu_pkg::MPU_WR_FAULT, 2'b00},
  '{32'h1000_0308, 1'b1, 1'b0, 1'b0, mpu_pkg::PRIV_M, 2'd1, mpu_pkg::MPU_WR_FAULT, 2'b00},
  '{32'h1000_030C, 1'b0, 1'b0, 1'b0, mpu_pkg::PRIV_M, 2'd1, mpu_pkg::MPU_OK, 2'b01},
  // Unlocked region and no match leave M-mode free
  '{32'h0000_0500, 1'b1, 1'b0, 1'b0, mpu_pkg::PRIV_M, 2'd1, mpu_pkg::MPU_OK, 2'b11},
  '{32'h8000_0200, 1'b0, 1'b0, 1'b0, mpu_pkg::PRIV_U, 2'd1, mpu_pkg::MPU_RE_FAULT, 2'b00},
  '{32'h8000_0200, 1'b0, 1'b0, 1'b0, mpu_pkg::PRIV_M, 2'd1, mpu_pkg::MPU_OK, 2'b10},
  // Locked NAPOT over ROM without X
  '{32'h8000_0300, 1'b0, 1'b1, 1'b0, mpu_pkg::PRIV_M, 2'd2, mpu_pkg::MPU_RE_FAULT, 2'b00},
  '{32'h8000_0304, 1'b0, 1'b0, 1'b0, mpu_pkg::PRIV_M, 2'd2, mpu_pkg::MPU_OK, 2'b10},
  '{32'h0000_0600, 1'b1, 1'b0, 1'b0, mpu_pkg::PRIV_M, 2'd2, mpu_pkg::MPU_OK, 2'b11},
  '{32'h0000_0600, 1'b0, 1'b0, 1'b0, mpu_pkg::PRIV_U, 2'd2, mpu_pkg::MPU_RE_FAULT, 2'b00}
};

`endif

/* tb/mpu_tb.sv */
// Testbench for the MPU top level that runs the request table against a random-delay bus model
`timescale 1ns/1ns
`default_nettype none

module mpu_tb;

  typedef struct packed {
    logic [31:0]          addr;
    logic                 we;
    logic                 exec;
    logic                 misaligned;
    mpu_pkg::priv_lvl_e   priv;
    logic [1:0]           pmp_set;
    mpu_pkg::mpu_status_e status;
    logic [1:0]           memtype;
  } case_t;

  `include "mpu_tb_cases.svh"

  localparam int HANDSHAKE_TIMEOUT = 50;
  localparam int DRAIN_TIMEOUT     = 100;

  logic                 clk;
  logic                 rst_n;
  logic                 core_valid_i;
  logic                 core_ready_o;
  logic [31:0]          core_addr_i;
  logic                 core_we_i;
  logic                 core_exec_i;
  logic                 core_misaligned_i;
  logic [31:0]          core_wdata_i;
  mpu_pkg::priv_lvl_e   core_priv_i;
  logic [3:0][7:0]      pmp_cfg_i;
  logic [3:0][31:0]     pmp_addr_i;
  logic                 bus_valid_o;
  logic                 bus_ready_i;
  logic [31:0]          bus_addr_o;
  logic                 bus_we_o;
  logic [31:0]          bus_wdata_o;
  logic [1:0]           bus_memtype_o;
  logic                 bus_resp_valid_i;
  logic [31:0]          bus_rdata_i;
  logic                 bus_err_i;
  logic                 core_resp_valid_o;
  logic [31:0]          core_rdata_o;
  logic                 core_bus_err_o;
  mpu_pkg::mpu_status_e core_status_o;
  logic                 core_mpu_err_o;

  int                   error_count = 0;
  int                   bus_count   = 0;
  int                   clean_count = 0;
  int                   cycle_cnt   = 0;
  bit                   aborted     = 1'b0;
  logic [31:0]          lcg_state   = 32'd71;
  logic [31:0]          inflight_addr [$];
  int                   inflight_due  [$];
  mpu_pkg::mpu_status_e exp_status_q  [$];
  logic [31:0]          exp_rdata_q   [$];

  mpu_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Next value of the pseudo random sequence
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else begin
      error_count++;
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  //////////////////////////////////////////////////
  // Bus model
  //////////////////////////////////////////////////

  // Random ready and in-order answers after 0 to 3 extra cycles
  // Read data is the inverted address and the error bit is random
  initial begin : bus_model
    bus_ready_i      = 1'b0;
    bus_resp_valid_i = 1'b0;
    bus_rdata_i      = '0;
    bus_err_i        = 1'b0;
    forever begin
      @(posedge clk);
      cycle_cnt++;
      if (rst_n && bus_valid_o && bus_ready_i) begin
        bus_count++;
        lcg_state = lcg_next(lcg_state);
        inflight_addr.push_back(bus_addr_o);
        inflight_due.push_back(cycle_cnt + int'(lcg_state[21:20]));
      end
      @(negedge clk);
      lcg_state   = lcg_next(lcg_state);
      // Ready roughly three cycles out of four
      bus_ready_i = (lcg_state[17:16] != 2'b00);
      if (inflight_addr.size() != 0 && inflight_due[0] <= cycle_cnt) begin
        bus_resp_valid_i = 1'b1;
        bus_rdata_i      = ~inflight_addr.pop_front();
        bus_err_i        = lcg_state[25];
        void'(inflight_due.pop_front());
      end else begin
        bus_resp_valid_i = 1'b0;
        bus_rdata_i      = '0;
        bus_err_i        = 1'b0;
      end
    end
  end

  // Each core response must match the oldest accepted request
  always @(posedge clk) begin
    if (rst_n && core_resp_valid_o) begin
      assert (exp_status_q.size() != 0)
      else begin
        error_count++;
        $display("Core response at %0t ns arrived with no request waiting for one", $time);
      end
      if (exp_status_q.size() != 0) begin
        check_value("core_status_o", exp_status_q[0], core_status_o);
        check_value("core_rdata_o", exp_rdata_q[0], core_rdata_o);
        // Bus error bit passes through only on a bus response
        check_value("core_bus_err_o",
                    (exp_status_q[0] == mpu_pkg::MPU_OK) ? bus_err_i : 1'b0,
                    core_bus_err_o);
        void'(exp_status_q.pop_front());
        void'(exp_rdata_q.pop_front());
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic apply_request(input int idx, input case_t row);
    int   wait_cycles;
    bit   accepted;
    logic fault;
    fault = (row.status != mpu_pkg::MPU_OK);
    @(negedge clk);
    pmp_cfg_i         = PMP_CFG_SET[row.pmp_set];
    pmp_addr_i        = PMP_ADDR_SET[row.pmp_set];
    core_valid_i      = 1'b1;
    core_addr_i       = row.addr;
    core_we_i         = row.we;
    core_exec_i       = row.exec;
    core_misaligned_i = row.misaligned;
    core_priv_i       = row.priv;
    core_wdata_i      = row.addr ^ 32'h5A5A_5A5A;
    accepted    = 1'b0;
    wait_cycles = 0;
    while (!accepted && wait_cycles < HANDSHAKE_TIMEOUT) begin
      @(posedge clk);
      if (core_ready_o) begin
        accepted = 1'b1;
      end else begin
        wait_cycles++;
      end
    end
    if (!accepted) begin
      error_count++;
      aborted = 1'b1;
      $display("Request %0d was never accepted by the MPU", idx);
    end else begin
      // Fault flag pulses at acceptance and only clean requests reach the bus
      check_value("core_mpu_err_o", fault, core_mpu_err_o);
      check_value("bus_valid_o", !fault, bus_valid_o);
      if (!fault) begin
        clean_count++;
        check_value("bus_addr_o", row.addr, bus_addr_o);
        check_value("bus_we_o", row.we, bus_we_o);
        check_value("bus_wdata_o", row.addr ^ 32'h5A5A_5A5A, bus_wdata_o);
        check_value("bus_memtype_o", row.memtype, bus_memtype_o);
      end
      exp_status_q.push_back(row.status);
      exp_rdata_q.push_back(fault ? 32'd0 : ~row.addr);
    end
  endtask

  initial begin : main
    int wait_cycles;
    rst_n             = 1'b0;
    core_valid_i      = 1'b0;
    core_addr_i       = '0;
    core_we_i         = 1'b0;
    core_exec_i       = 1'b0;
    core_misaligned_i = 1'b0;
    core_wdata_i      = '0;
    core_priv_i       = mpu_pkg::PRIV_M;
    pmp_cfg_i         = PMP_CFG_SET[0];
    pmp_addr_i        = PMP_ADDR_SET[0];
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    // Quiet outputs out of reset
    check_value("core_resp_valid_o", 32'd0, core_resp_valid_o);
    check_value("bus_valid_o", 32'd0, bus_valid_o);
    check_value("core_mpu_err_o", 32'd0, core_mpu_err_o);

    for (int i = 0; i < NUM_CASES && !aborted; i++) begin
      apply_request(i, CASES[i]);
    end
    @(negedge clk);
    core_valid_i = 1'b0;

    // Let every outstanding response come back
    wait_cycles = 0;
    while (exp_status_q.size() != 0 && wait_cycles < DRAIN_TIMEOUT) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (exp_status_q.size() != 0) begin
      error_count++;
      $display("%0d responses never reached the core", exp_status_q.size());
    end else if (!aborted) begin
      check_value("bus handshakes", clean_count, bus_count);
    end

    $display("Requests: %0d, bus transactions: %0d, errors: %0d",
             NUM_CASES, bus_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/mpu_top.sv */
// MPU top level, plain core, bus and PMP ports wired to the PMP, PMA and gate stages
`timescale 1ns/1ns
`default_nettype none

module mpu_top (
  input  logic                       clk,
  input  logic                       rst_n,

  // Core request
  input  logic                       core_valid_i,
  output logic                       core_ready_o,
  input  logic [mpu_pkg::ADDR_W-1:0] core_addr_i,
  input  logic                       core_we_i,
  input  logic                       core_exec_i,
  input  logic                       core_misaligned_i,
  input  logic [mpu_pkg::DATA_W-1:0] core_wdata_i,
  input  mpu_pkg::priv_lvl_e         core_priv_i,

  // PMP configuration
  input  logic [mpu_pkg::PMP_NUM_REGIONS-1:0][mpu_pkg::PMP_CFG_W-1:0] pmp_cfg_i,
  input  logic [mpu_pkg::PMP_NUM_REGIONS-1:0][mpu_pkg::ADDR_W-1:0]    pmp_addr_i,

  // Bus request
  output logic                       bus_valid_o,
  input  logic                       bus_ready_i,
  output logic [mpu_pkg::ADDR_W-1:0] bus_addr_o,
  output logic                       bus_we_o,
  output logic [mpu_pkg::DATA_W-1:0] bus_wdata_o,
  output logic [1:0]                 bus_memtype_o,

  // Bus response
  input  logic                       bus_resp_valid_i,
  input  logic [mpu_pkg::DATA_W-1:0] bus_rdata_i,
  input  logic                       bus_err_i,

  // Core response
  output logic                       core_resp_valid_o,
  output logic [mpu_pkg::DATA_W-1:0] core_rdata_o,
  output logic                       core_bus_err_o,
  output mpu_pkg::mpu_status_e       core_status_o,
  output logic                       core_mpu_err_o
);

  mpu_chk_if chk ();

  // Request fields into the check interface
  assign chk.addr       = core_addr_i;
  assign chk.we         = core_we_i;
  assign chk.exec       = core_exec_i;
  assign chk.misaligned = core_misaligned_i;
  assign chk.priv       = core_priv_i;

  mpu_pmp u_pmp (
    .chk        (chk),
    .pmp_cfg_i  (pmp_cfg_i),
    .pmp_addr_i (pmp_addr_i)
  );

  mpu_pma u_pma (
    .chk (chk)
  );

  mpu_gate u_gate (
    .clk               (clk),
    .rst_n             (rst_n),
    .chk               (chk),
    .core_valid_i      (core_valid_i),
    .core_ready_o      (core_ready_o),
    .core_wdata_i      (core_wdata_i),
    .bus_valid_o       (bus_valid_o),
    .bus_ready_i       (bus_ready_i),
    .bus_addr_o        (bus_addr_o),
    .bus_we_o          (bus_we_o),
    .bus_wdata_o       (bus_wdata_o),
    .bus_memtype_o     (bus_memtype_o),
    .bus_resp_valid_i  (bus_resp_valid_i),
    .bus_rdata_i       (bus_rdata_i),
    .bus_err_i         (bus_err_i),
    .core_resp_valid_o (core_resp_valid_o),
    .core_rdata_o      (core_rdata_o),
    .core_bus_err_o    (core_bus_err_o),
    .core_status_o     (core_status_o),
    .core_mpu_err_o    (core_mpu_err_o)
  );

endmodule

`default_nettype wire

/* logic/mpu_gate.sv */
// MPU gate that forwards clean requests to the bus and consumes failing ones with a deferred fault
`timescale 1ns/1ns
`default_nettype none

module mpu_gate (
  input  logic                        clk,
  input  logic                        rst_n,
  mpu_chk_if.gate                     chk,

  // Core request
  input  logic                        core_valid_i,
  output logic                        core_ready_o,
  input  logic [mpu_pkg::DATA_W-1:0]  core_wdata_i,

  // Bus request
  output logic                        bus_valid_o,
  input  logic                        bus_ready_i,
  output logic [mpu_pkg::ADDR_W-1:0]  bus_addr_o,
  output logic                        bus_we_o,
  output logic [mpu_pkg::DATA_W-1:0]  bus_wdata_o,
  output logic [1:0]                  bus_memtype_o,

  // Bus response
  input  logic                        bus_resp_valid_i,
  input  logic [mpu_pkg::DATA_W-1:0]  bus_rdata_i,
  input  logic                        bus_err_i,

  // Core response
  output logic                        core_resp_valid_o,
  output logic [mpu_pkg::DATA_W-1:0]  core_rdata_o,
  output logic                        core_bus_err_o,
  output mpu_pkg::mpu_status_e        core_status_o,
  output logic                        core_mpu_err_o
);

  mpu_pkg::mpu_state_e         state_q;
  mpu_pkg::mpu_state_e         state_n;
  mpu_pkg::mpu_status_e        status;
  logic [mpu_pkg::OUTST_W-1:0] outst_q;
  logic [mpu_pkg::OUTST_W-1:0] outst_n;
  logic                        outst_full;
  logic                        idle;
  logic                        mpu_err;
  logic                        err_accept;
  logic                        bus_hs;
  logic                        fault_resp;

  assign mpu_err    = chk.pmp_err || chk.pma_err;
  assign idle       = (state_q == mpu_pkg::MPU_IDLE);
  assign outst_full = &outst_q;

  // Failing request taken by the gate itself
  assign err_accept = idle && core_valid_i && mpu_err;

  //////////////////////////////////////////////////
  // Request path
  //////////////////////////////////////////////////

  assign bus_valid_o  = core_valid_i && idle && !mpu_err && !outst_full;
  assign bus_hs       = bus_valid_o && bus_ready_i;
  // Failing requests are accepted at once and clean ones follow the bus ready
  assign core_ready_o = idle && (mpu_err || (bus_ready_i && !outst_full));

  assign bus_addr_o    = chk.addr;
  assign bus_we_o      = chk.we;
  assign bus_wdata_o   = core_wdata_i;
  // Cacheable in bit 1 and bufferable in bit 0
  assign bus_memtype_o = {chk.cacheable, chk.bufferable};

  // Outstanding count rises on a bus handshake and falls on a bus response
  always_comb begin
    outst_n = outst_q;
    if (bus_hs && !bus_resp_valid_i) begin
      outst_n = outst_q + 1'b1;
    end else if (!bus_hs && bus_resp_valid_i) begin
      outst_n = outst_q - 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Fault FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_n    = state_q;
    status     = mpu_pkg::MPU_OK;
    fault_resp = 1'b0;
    case (state_q)
      mpu_pkg::MPU_IDLE: begin
        if (err_accept) begin
          // Respond next cycle once nothing is left in flight
          if (outst_n == '0) begin
            state_n = chk.we ? mpu_pkg::MPU_WR_RESP : mpu_pkg::MPU_RE_RESP;
          end else begin
            state_n = chk.we ? mpu_pkg::MPU_WR_WAIT : mpu_pkg::MPU_RE_WAIT;
          end
        end
      end
      mpu_pkg::MPU_RE_WAIT: begin
        if (outst_n == '0) begin
          state_n = mpu_pkg::MPU_RE_RESP;
        end
      end
      mpu_pkg::MPU_WR_WAIT: begin
        if (outst_n == '0) begin
          state_n = mpu_pkg::MPU_WR_RESP;
        end
      end
      mpu_pkg::MPU_RE_RESP: begin
        fault_resp = 1'b1;
        status     = mpu_pkg::MPU_RE_FAULT;
        state_n    = mpu_pkg::MPU_IDLE;
      end
      mpu_pkg::MPU_WR_RESP: begin
        fault_resp = 1'b1;
        status     = mpu_pkg::MPU_WR_FAULT;
        state_n    = mpu_pkg::MPU_IDLE;
      end
      default: begin
        state_n = mpu_pkg::MPU_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= mpu_pkg::MPU_IDLE;
      outst_q <= '0;
    end else begin
      state_q <= state_n;
      outst_q <= outst_n;
    end
  end

  //////////////////////////////////////////////////
  // Response path
  //////////////////////////////////////////////////

  // No bus response can collide with a fault response since the count is zero then
  assign core_resp_valid_o = bus_resp_valid_i || fault_resp;
  assign core_rdata_o      = fault_resp ? '0 : bus_rdata_i;
  assign core_bus_err_o    = !fault_resp && bus_err_i;
  assign core_status_o     = status;
  assign core_mpu_err_o    = err_accept;

  // Gate leaves idle after taking a fault, so the next cycle is quiet
  a_bus_quiet_after_fault : assert property (@(posedge clk) disable iff (!rst_n)
    err_accept |=> (!bus_valid_o && !core_ready_o));

  // Bus answers only what was handed to it
  a_resp_outstanding : assert property (@(posedge clk) disable iff (!rst_n)
    bus_resp_valid_i |-> (outst_q != '0));

  // A full count never wraps to zero
  a_outst_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
    outst_full |=> (outst_q != '0));

endmodule

`default_nettype wire

/* logic/mpu_pma.sv */
// PMA lookup of the current request in the fixed region table, yields error and memory type bits
`timescale 1ns/1ns
`default_nettype none

module mpu_pma (
  mpu_chk_if.pma chk
);

  logic [mpu_pkg::PMA_NUM_REGIONS-1:0] region_hit;
  logic                                any_hit;
  logic                                exec_ok;
  logic                                misalign_ok;

  //////////////////////////////////////////////////
  // Region lookup
  //////////////////////////////////////////////////

  // Table regions never overlap, at most one bit is set
  always_comb begin
    for (int i = 0; i < mpu_pkg::PMA_NUM_REGIONS; i++) begin
      region_hit[i] = (chk.addr >= mpu_pkg::PMA_BASE[i]) &&
                      (chk.addr <= mpu_pkg::PMA_LAST[i]);
    end
  end

  assign any_hit = |region_hit;

  // Attributes of the hit region, all zero on a miss
  assign exec_ok     = |(region_hit & mpu_pkg::PMA_EXEC);
  assign misalign_ok = |(region_hit & mpu_pkg::PMA_MISALIGN);

  assign chk.cacheable  = |(region_hit & mpu_pkg::PMA_CACHEABLE);
  assign chk.bufferable = |(region_hit & mpu_pkg::PMA_BUFFERABLE);

  //////////////////////////////////////////////////
  // Error verdict
  //////////////////////////////////////////////////

  // Unmapped address
  // or fetch from a data-only region
  // or misaligned access where the region forbids it
  assign chk.pma_err = !any_hit ||
                       (chk.exec && !exec_ok) ||
                       (chk.misaligned && !misalign_ok);

endmodule

`default_nettype wire

/* logic/mpu_pmp.sv */
// PMP check of the current request against four CSR regions, combinational, flags pmp_err
`timescale 1ns/1ns
`default_nettype none

module mpu_pmp (
  mpu_chk_if.pmp chk,
  input  logic [mpu_pkg::PMP_NUM_REGIONS-1:0][mpu_pkg::PMP_CFG_W-1:0] pmp_cfg_i,
  input  logic [mpu_pkg::PMP_NUM_REGIONS-1:0][mpu_pkg::ADDR_W-1:0]    pmp_addr_i
);

  mpu_pkg::pmp_acc_e                   acc;
  logic [mpu_pkg::ADDR_W-1:0]          req_word;
  logic [mpu_pkg::PMP_NUM_REGIONS-1:0] region_hit;
  logic [mpu_pkg::PMP_NUM_REGIONS-1:0] region_perm;
  logic [mpu_pkg::PMP_NUM_REGIONS-1:0] region_lock;
  logic                                pmp_err;

  // Fetch wins over write when both are set
  always_comb begin
    if (chk.exec) begin
      acc = mpu_pkg::ACC_EXEC;
    end else if (chk.we) begin
      acc = mpu_pkg::ACC_WRITE;
    end else begin
      acc = mpu_pkg::ACC_READ;
    end
  end

  // Word address in the same units as pmpaddr
  assign req_word = {2'b00, chk.addr[mpu_pkg::ADDR_W-1:2]};

  //////////////////////////////////////////////////
  // Per-region match and permission
  //////////////////////////////////////////////////

  for (genvar i = 0; i < mpu_pkg::PMP_NUM_REGIONS; i++) begin : g_region
    logic [mpu_pkg::PMP_CFG_W-1:0] cfg;
    mpu_pkg::pmp_mode_e            mode;
    logic [mpu_pkg::ADDR_W-1:0]    lo_bound;
    logic [mpu_pkg::ADDR_W-1:0]    napot_mask;
    logic                          hit;
    logic                          perm;

    assign cfg  = pmp_cfg_i[i];
    assign mode = mpu_pkg::pmp_mode_e'(cfg[mpu_pkg::PMP_A_LO +: 2]);

    // TOR lower bound comes from the entry below, zero for entry 0
    if (i == 0) begin : g_first
      assign lo_bound = '0;
    end else begin : g_next
      assign lo_bound = pmp_addr_i[i-1];
    end

    // Trailing ones plus the next zero are don't-care bits
    assign napot_mask = ~(pmp_addr_i[i] ^ (pmp_addr_i[i] + 1'b1));

    always_comb begin
      case (mode)
        mpu_pkg::PMP_TOR:   hit = (req_word >= lo_bound) && (req_word < pmp_addr_i[i]);
        mpu_pkg::PMP_NA4:   hit = (req_word == pmp_addr_i[i]);
        mpu_pkg::PMP_NAPOT: hit = ((req_word & napot_mask) == (pmp_addr_i[i] & napot_mask));
        default:            hit = 1'b0;
      endcase
    end

    // Permission bit for this access kind
    always_comb begin
      case (acc)
        mpu_pkg::ACC_WRITE: perm = cfg[mpu_pkg::PMP_W];
        mpu_pkg::ACC_EXEC:  perm = cfg[mpu_pkg::PMP_X];
        default:            perm = cfg[mpu_pkg::PMP_R];
      endcase
    end

    assign region_hit[i]  = hit;
    assign region_perm[i] = perm;
    assign region_lock[i] = cfg[mpu_pkg::PMP_L];
  end

  //////////////////////////////////////////////////
  // Priority and privilege rules
  //////////////////////////////////////////////////

  // Walk down so the lowest matching entry is the last one applied
  always_comb begin
    // No match, M passes and U fails
    pmp_err = (chk.priv != mpu_pkg::PRIV_M);
    for (int i = mpu_pkg::PMP_NUM_REGIONS - 1; i >= 0; i--) begin
      if (region_hit[i]) begin
        if (chk.priv == mpu_pkg::PRIV_M) begin
          // M-mode only bound by locked entries
          pmp_err = region_lock[i] && !region_perm[i];
        end else begin
          pmp_err = !region_perm[i];
        end
      end
    end
  end

  assign chk.pmp_err = pmp_err;

endmodule

`default_nettype wire

/* logic/mpu_chk_if.sv */
// Request fields and check verdicts shared by the MPU stages, one modport per stage
`timescale 1ns/1ns
`default_nettype none

interface mpu_chk_if;

  // Request fields, driven by the top level
  logic [mpu_pkg::ADDR_W-1:0] addr;
  logic                       we;
  logic                       exec;
  logic                       misaligned;
  mpu_pkg::priv_lvl_e         priv;

  // Verdicts from the check stages
  logic                       pmp_err;
  logic                       pma_err;
  logic                       cacheable;
  logic                       bufferable;

  // PMP stage
  modport pmp (
    input  addr, we, exec, priv,
    output pmp_err
  );

  // PMA stage
  modport pma (
    input  addr, exec, misaligned,
    output pma_err, cacheable, bufferable
  );

  // Gate sees the whole request and every verdict
  modport gate (
    input addr, we, exec, misaligned, priv,
    input pmp_err, pma_err, cacheable, bufferable
  );

endinterface

`default_nettype wire

/* logic/mpu_pkg.sv */
// Shared widths, PMA table, PMP bit positions and enums for the MPU, referenced by scoped names
`default_nettype none

package mpu_pkg;

  //////////////////////////////////////////////////
  // Widths and counts
  //////////////////////////////////////////////////

  localparam int unsigned ADDR_W          = 32;
  localparam int unsigned DATA_W          = 32;
  localparam int unsigned PMP_NUM_REGIONS = 4;
  localparam int unsigned PMA_NUM_REGIONS = 3;
  // Up to three transactions in flight
  localparam int unsigned OUTST_W         = 2;

  //////////////////////////////////////////////////
  // PMA table
  //////////////////////////////////////////////////

  // Region 0 main RAM, 1 peripherals, 2 boot ROM
  localparam logic [ADDR_W-1:0] PMA_BASE [PMA_NUM_REGIONS] = '{
    32'h0000_0000, 32'h1000_0000, 32'h8000_0000
  };
  localparam logic [ADDR_W-1:0] PMA_LAST [PMA_NUM_REGIONS] = '{
    32'h0003_FFFF, 32'h1000_FFFF, 32'h8000_FFFF
  };
  // Attribute bit i belongs to region i
  localparam logic [PMA_NUM_REGIONS-1:0] PMA_CACHEABLE  = 3'b101;
  localparam logic [PMA_NUM_REGIONS-1:0] PMA_BUFFERABLE = 3'b011;
  localparam logic [PMA_NUM_REGIONS-1:0] PMA_EXEC       = 3'b101;
  // Set where a misaligned access is allowed
  localparam logic [PMA_NUM_REGIONS-1:0] PMA_MISALIGN   = 3'b101;

  //////////////////////////////////////////////////
  // PMP configuration byte
  //////////////////////////////////////////////////

  localparam int unsigned PMP_CFG_W = 8;
  localparam int unsigned PMP_R     = 0;
  localparam int unsigned PMP_W     = 1;
  localparam int unsigned PMP_X     = 2;
  // Address matching mode occupies two bits from here
  localparam int unsigned PMP_A_LO  = 3;
  localparam int unsigned PMP_L     = 7;

  typedef enum logic [1:0] {
    PMP_OFF   = 2'd0,
    PMP_TOR   = 2'd1,
    PMP_NA4   = 2'd2,
    PMP_NAPOT = 2'd3
  } pmp_mode_e;

  //////////////////////////////////////////////////
  // Privilege, access kind, status and gate state
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_M = 2'd3
  } priv_lvl_e;

  typedef enum logic [1:0] {
    ACC_READ,
    ACC_WRITE,
    ACC_EXEC
  } pmp_acc_e;

  typedef enum logic [1:0] {
    MPU_OK,
    MPU_RE_FAULT,
    MPU_WR_FAULT
  } mpu_status_e;

  typedef enum logic [2:0] {
    MPU_IDLE,
    MPU_RE_WAIT,
    MPU_WR_WAIT,
    MPU_RE_RESP,
    MPU_WR_RESP
  } mpu_state_e;

endpackage

`default_nettype wire
